// ==== hw/md_pkg.sv ====
package md_pkg;

	localparam int default_width = 32; // Word width of the RV32 datapath.

	// The sign mode picks the signed variant of each operator.
	typedef enum logic [1:0] {
		MD_OP_MULL = 2'd0,
		MD_OP_MULH = 2'd1,
		MD_OP_DIV  = 2'd2,
		MD_OP_REM  = 2'd3
	} md_op_e;

	typedef logic [1:0] md_sign_t; // Bit 0 marks operand a signed, bit 1 operand b.

endpackage

// ==== hw/md_operand_stage.sv ====
`timescale 1ns/1ps

module md_operand_stage #(
	parameter int width = md_pkg::default_width
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             req_i,
	input  logic             busy_i,
	input  logic [width-1:0] op_a_i,
	input  logic [width-1:0] op_b_i,
	input  md_pkg::md_op_e   operator_i,
	input  md_pkg::md_sign_t signed_mode_i,
	output logic [width-1:0] op_a_o,
	output logic [width-1:0] op_b_o,
	output md_pkg::md_op_e   operator_o,
	output md_pkg::md_sign_t signed_mode_o,
	output logic             mult_start_o,
	output logic             div_start_o
);
	import md_pkg::*;

	logic armed_q;
	logic accept;
	logic is_mult;

	assign accept  = req_i & ~busy_i & armed_q;
	assign is_mult = (operator_i == MD_OP_MULL) || (operator_i == MD_OP_MULH);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			armed_q      <= 1'b1;
			mult_start_o <= 1'b0;
			div_start_o  <= 1'b0;
		end else begin
			mult_start_o <= accept & is_mult;
			div_start_o  <= accept & ~is_mult;
			if (accept) begin
				armed_q <= 1'b0;
			end else if (!req_i) begin
				armed_q <= 1'b1; // A request is taken only once per req_i pulse.
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_a_o        <= op_a_i;
			op_b_o        <= op_b_i;
			operator_o    <= operator_i;
			signed_mode_o <= signed_mode_i;
		end
	end

endmodule

// ==== hw/md_multiplier.sv ====
`timescale 1ns/1ps

module md_multiplier #(
	parameter int width = md_pkg::default_width
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             start_i,
	input  logic [width-1:0] op_a_i,
	input  logic [width-1:0] op_b_i,
	input  md_pkg::md_op_e   operator_i,
	input  md_pkg::md_sign_t signed_mode_i,
	output logic             done_o,
	output logic [width-1:0] result_o
);
	import md_pkg::*;

	localparam int half = width / 2;

	typedef enum logic [1:0] {
		ALBL,
		ALBH,
		AHBL,
		AHBH
	} md_mult_state_e;

	md_mult_state_e state_q;
	md_mult_state_e state_d;
	logic active_q;
	logic last;
	logic is_mull;
	logic signed_mult;
	logic [half-1:0] mul_a;
	logic [half-1:0] mul_b;
	logic sign_a;
	logic sign_b;
	logic [width+1:0] accum;
	logic [width+1:0] mac_res;
	logic [width+1:0] acc_q;
	logic [width+1:0] acc_d;

	assign is_mull     = operator_i == MD_OP_MULL;
	assign signed_mult = signed_mode_i != 2'b00;

	// One half-word product per cycle, summed into the running accumulator.
	assign mac_res = $signed({sign_a, mul_a}) * $signed({sign_b, mul_b}) + $signed(accum);

	always_comb begin
		mul_a   = op_a_i[half-1:0];
		mul_b   = op_b_i[half-1:0];
		sign_a  = 1'b0;
		sign_b  = 1'b0;
		accum   = '0;
		acc_d   = mac_res;
		state_d = state_q;
		last    = 1'b0;
		case (state_q)
			ALBL: begin
				state_d = ALBH;
			end
			ALBH: begin
				mul_b  = op_b_i[width-1:half];
				sign_b = signed_mode_i[1] & op_b_i[width-1];
				accum  = {{(half + 2){1'b0}}, acc_q[width-1:half]};
				if (is_mull) begin
					acc_d = {2'b00, mac_res[half-1:0], acc_q[half-1:0]}; // Low word only.
				end
				state_d = AHBL;
			end
			AHBL: begin
				mul_a  = op_a_i[width-1:half];
				sign_a = signed_mode_i[0] & op_a_i[width-1];
				if (is_mull) begin
					accum   = {{(half + 2){1'b0}}, acc_q[width-1:half]};
					last    = 1'b1;
					state_d = ALBL;
				end else begin
					accum   = acc_q;
					state_d = AHBH;
				end
			end
			AHBH: begin
				mul_a   = op_a_i[width-1:half];
				mul_b   = op_b_i[width-1:half];
				sign_a  = signed_mode_i[0] & op_a_i[width-1];
				sign_b  = signed_mode_i[1] & op_b_i[width-1];
				accum   = {{half{signed_mult & acc_q[width+1]}}, acc_q[width+1:half]};
				last    = 1'b1;
				state_d = ALBL;
			end
			default: state_d = ALBL;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			active_q <= 1'b0;
			state_q  <= ALBL;
		end else if (start_i) begin
			active_q <= 1'b1;
			state_q  <= ALBL;
		end else if (active_q) begin
			state_q <= state_d;
			if (last) begin
				active_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (active_q) begin
			acc_q <= acc_d;
		end
	end

	assign done_o   = active_q & last;
	assign result_o = (state_q == AHBH) ? mac_res[width-1:0]
	                                    : {mac_res[half-1:0], acc_q[half-1:0]};

endmodule

// ==== hw/md_divider.sv ====
`timescale 1ns/1ps

module md_divider #(
	parameter int width = md_pkg::default_width
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             start_i,
	input  logic [width-1:0] op_a_i,
	input  logic [width-1:0] op_b_i,
	input  md_pkg::md_op_e   operator_i,
	input  md_pkg::md_sign_t signed_mode_i,
	output logic             done_o,
	output logic [width-1:0] result_o
);
	import md_pkg::*;

	localparam int cw = $clog2(width);

	typedef enum logic [2:0] {
		IDLE,
		ABS_A,
		ABS_B,
		COMP,
		LAST,
		CHANGE_SIGN,
		FINISH
	} md_div_state_e;

	md_div_state_e state_q;
	md_div_state_e state_d;
	logic go_q;
	logic [cw-1:0] cnt_q;
	logic [cw-1:0] cnt_d;
	logic [cw-1:0] cnt_dec;
	logic [width-1:0] numer_q;
	logic [width-1:0] numer_d;
	logic [width-1:0] denom_q;
	logic [width-1:0] denom_d;
	logic [width-1:0] quot_q;
	logic [width-1:0] quot_d;
	logic [width-1:0] rem_q;
	logic [width-1:0] rem_d;
	logic [width-1:0] sub_a;
	logic [width-1:0] sub_b;
	logic [width:0] sub_res;
	logic ge;
	logic [width-1:0] one_shift;
	logic [width-1:0] next_rem;
	logic [width-1:0] next_quot;
	logic is_div;
	logic sign_a;
	logic sign_b;
	logic div_change_sign;
	logic rem_change_sign;

	// Shared subtractor for negation and the compare step.
	assign sub_res = {1'b0, sub_a} - {1'b0, sub_b};
	assign ge      = ~sub_res[width]; // No borrow means remainder >= divisor.

	assign cnt_dec   = cnt_q - 1'b1;
	assign one_shift = {{(width - 1){1'b0}}, 1'b1} << cnt_q;
	assign next_rem  = ge ? sub_res[width-1:0] : rem_q;
	assign next_quot = ge ? (quot_q | one_shift) : quot_q;

	assign is_div          = operator_i == MD_OP_DIV;
	assign sign_a          = signed_mode_i[0] & op_a_i[width-1];
	assign sign_b          = signed_mode_i[1] & op_b_i[width-1];
	assign div_change_sign = sign_a ^ sign_b;
	assign rem_change_sign = sign_a; // The remainder follows the dividend.

	always_comb begin
		state_d = state_q;
		cnt_d   = cnt_q;
		numer_d = numer_q;
		denom_d = denom_q;
		quot_d  = quot_q;
		rem_d   = rem_q;
		sub_a   = rem_q;
		sub_b   = denom_q;
		case (state_q)
			IDLE: begin
				if (go_q) begin
					if (op_b_i == '0) begin
						rem_d   = is_div ? '1 : op_a_i;
						state_d = FINISH;
					end else begin
						state_d = ABS_A;
					end
				end
			end
			ABS_A: begin
				sub_a   = '0;
				sub_b   = op_a_i;
				numer_d = sign_a ? sub_res[width-1:0] : op_a_i;
				quot_d  = '0;
				state_d = ABS_B;
			end
			ABS_B: begin
				sub_a   = '0;
				sub_b   = op_b_i;
				denom_d = sign_b ? sub_res[width-1:0] : op_b_i;
				rem_d   = {{(width - 1){1'b0}}, numer_q[width-1]};
				cnt_d   = cw'(width - 1);
				state_d = COMP;
			end
			COMP: begin
				rem_d   = {next_rem[width-2:0], numer_q[cnt_dec]};
				quot_d  = next_quot;
				cnt_d   = cnt_dec;
				state_d = (cnt_q == cw'(1)) ? LAST : COMP;
			end
			LAST: begin
				rem_d   = is_div ? next_quot : next_rem;
				state_d = CHANGE_SIGN;
			end
			CHANGE_SIGN: begin
				sub_a = '0;
				sub_b = rem_q;
				if (is_div ? div_change_sign : rem_change_sign) begin
					rem_d = sub_res[width-1:0];
				end
				state_d = FINISH;
			end
			FINISH: begin
				state_d = IDLE;
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= IDLE;
			go_q    <= 1'b0;
			cnt_q   <= '0;
		end else begin
			state_q <= state_d;
			go_q    <= start_i;
			cnt_q   <= cnt_d;
		end
	end

	always_ff @(posedge clk_i) begin
		numer_q <= numer_d;
		denom_q <= denom_d;
		quot_q  <= quot_d;
		rem_q   <= rem_d;
	end

	assign done_o   = state_q == FINISH;
	assign result_o = rem_q; // Holds the final quotient or remainder in FINISH.

endmodule

// ==== hw/md_result_port.sv ====
`timescale 1ns/1ps

module md_result_port #(
	parameter int width = md_pkg::default_width
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             req_i,
	input  logic             mult_done_i,
	input  logic             div_done_i,
	input  logic [width-1:0] mult_result_i,
	input  logic [width-1:0] div_result_i,
	output logic             busy_o,
	output logic             ack_o,
	output logic [width-1:0] result_o
);

	logic req_q;
	logic ack_q;
	logic [width-1:0] result_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			req_q <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			req_q <= req_i;
			if (mult_done_i | div_done_i) begin
				ack_q <= 1'b1;
			end else if (!req_i) begin
				ack_q <= 1'b0; // Release once the requester has withdrawn.
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (div_done_i) begin
			result_q <= div_result_i;
		end else if (mult_done_i) begin
			result_q <= mult_result_i;
		end
	end

	// Busy from the start cycle until the ack has dropped.
	assign busy_o   = req_q | ack_q;
	assign ack_o    = ack_q;
	assign result_o = result_q;

endmodule

// ==== hw/md_unit.sv ====
`timescale 1ns/1ps

module md_unit #(
	parameter int width = md_pkg::default_width
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             req_i,
	input  logic [width-1:0] op_a_i,
	input  logic [width-1:0] op_b_i,
	input  md_pkg::md_op_e   operator_i,
	input  md_pkg::md_sign_t signed_mode_i,
	output logic             ack_o,
	output logic [width-1:0] result_o
);
	import md_pkg::*;

	logic [width-1:0] op_a;
	logic [width-1:0] op_b;
	md_op_e operator;
	md_sign_t signed_mode;
	logic mult_start;
	logic div_start;
	logic mult_done;
	logic div_done;
	logic [width-1:0] mult_result;
	logic [width-1:0] div_result;
	logic busy;

	md_operand_stage #(
		.width(width)
	) md_operand_stage_i (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.req_i        (req_i),
		.busy_i       (busy),
		.op_a_i       (op_a_i),
		.op_b_i       (op_b_i),
		.operator_i   (operator_i),
		.signed_mode_i(signed_mode_i),
		.op_a_o       (op_a),
		.op_b_o       (op_b),
		.operator_o   (operator),
		.signed_mode_o(signed_mode),
		.mult_start_o (mult_start),
		.div_start_o  (div_start)
	);

	md_multiplier #(
		.width(width)
	) md_multiplier_i (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.start_i      (mult_start),
		.op_a_i       (op_a),
		.op_b_i       (op_b),
		.operator_i   (operator),
		.signed_mode_i(signed_mode),
		.done_o       (mult_done),
		.result_o     (mult_result)
	);

	md_divider #(
		.width(width)
	) md_divider_i (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.start_i      (div_start),
		.op_a_i       (op_a),
		.op_b_i       (op_b),
		.operator_i   (operator),
		.signed_mode_i(signed_mode),
		.done_o       (div_done),
		.result_o     (div_result)
	);

	md_result_port #(
		.width(width)
	) md_result_port_i (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.req_i        (req_i),
		.mult_done_i  (mult_done),
		.div_done_i   (div_done),
		.mult_result_i(mult_result),
		.div_result_i (div_result),
		.busy_o       (busy),
		.ack_o        (ack_o),
		.result_o     (result_o)
	);

endmodule

// ==== tb/md_unit_tb.sv ====
`timescale 1ns/1ps

module md_unit_tb;
	import md_pkg::*;

	localparam int width = md_pkg::default_width;
	localparam int reset_cycles = 16;
	localparam int cycles_per_entry = 60;
	localparam int num_random = 24;
	localparam int ack_limit = 100; // Longest wait for one ack edge.
	localparam int div_zero_cycles = 4; // Accept, start, early exit to FINISH, then ack.
	localparam int div_cycles = width + 7;
	localparam logic [31:0] lcg_mul = 32'd1664525;
	localparam logic [31:0] lcg_inc = 32'd1013904223;

	typedef struct packed {
		md_op_e op;
		md_sign_t mode;
		logic [width-1:0] a;
		logic [width-1:0] b;
		logic [width-1:0] expected;
	} entry_t;

	logic clk;
	logic rst_n;
	logic req;
	logic [width-1:0] op_a;
	logic [width-1:0] op_b;
	md_op_e operator;
	md_sign_t signed_mode;
	logic ack;
	logic [width-1:0] result;

	entry_t table_q[$];
	logic [31:0] lcg_state = 32'h54c69b6a;

	md_unit #(
		.width(width)
	) md_unit_i (
		.clk_i        (clk),
		.rst_ni       (rst_n),
		.req_i        (req),
		.op_a_i       (op_a),
		.op_b_i       (op_b),
		.operator_i   (operator),
		.signed_mode_i(signed_mode),
		.ack_o        (ack),
		.result_o     (result)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * lcg_mul + lcg_inc;
		return lcg_state;
	endfunction

	// Reference arithmetic on 64-bit integers, following the RISC-V M rules.
	function automatic logic [width-1:0] model_result(input md_op_e op, input md_sign_t mode,
			input logic [width-1:0] a, input logic [width-1:0] b);
		longint sa;
		longint sb;
		logic [63:0] prod;
		sa = {{(64 - width){mode[0] & a[width-1]}}, a};
		sb = {{(64 - width){mode[1] & b[width-1]}}, b};
		prod = sa * sb;
		if (op == MD_OP_MULL) return prod[width-1:0];
		if (op == MD_OP_MULH) return prod[2*width-1:width];
		if (sb == 0) return (op == MD_OP_DIV) ? '1 : a;
		if (op == MD_OP_DIV) return width'(sa / sb); // Truncates toward zero.
		return width'(sa % sb);
	endfunction

	task automatic check_result(input logic [width-1:0] got, input logic [width-1:0] expected,
			input md_op_e op, input string what);
		if (got !== expected) begin
			$display("CHECK FAILED at %0t: %s %s gave %h, expected %h",
				$time, what, op.name(), got, expected);
			$display("Test failed");
			$fatal(1, "result mismatch");
		end
	endtask

	task automatic check_ack(input logic got, input logic expected, input string what);
		if (got !== expected) begin
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, expected);
			$display("Test failed");
			$fatal(1, "ack mismatch");
		end
	endtask

	task automatic check_latency(input int got, input int lo, input int hi, input string what);
		if (got < lo || got > hi) begin
			$display("CHECK FAILED at %0t: %s ack after %0d cycles, expected %0d to %0d",
				$time, what, got, lo, hi);
			$display("Test failed");
			$fatal(1, "latency mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("The DUT did not answer in time: %s", what);
		$display("Test failed");
		$fatal(1, "handshake timeout");
	endtask

	task automatic add_entry(input md_op_e op, input md_sign_t mode, input logic [width-1:0] a,
			input logic [width-1:0] b, input logic [width-1:0] expected);
		table_q.push_back({op, mode, a, b, expected});
	endtask

	task automatic build_table();
		logic [31:0] r;
		md_op_e op;
		md_sign_t mode;
		logic [width-1:0] a;
		logic [width-1:0] b;
		add_entry(MD_OP_MULL, 2'b00, 32'h00000003, 32'h00000007, 32'h00000015);
		add_entry(MD_OP_MULL, 2'b11, 32'hffffffff, 32'h00000005, 32'hfffffffb);
		add_entry(MD_OP_MULL, 2'b00, 32'h80000000, 32'h80000000, 32'h00000000);
		add_entry(MD_OP_MULL, 2'b00, 32'h00010001, 32'h00010001, 32'h00020001);
		add_entry(MD_OP_MULH, 2'b11, 32'h80000000, 32'h80000000, 32'h40000000);
		add_entry(MD_OP_MULH, 2'b00, 32'h80000000, 32'h80000000, 32'h40000000);
		add_entry(MD_OP_MULH, 2'b00, 32'hffffffff, 32'hffffffff, 32'hfffffffe);
		add_entry(MD_OP_MULH, 2'b11, 32'hffffffff, 32'hffffffff, 32'h00000000);
		add_entry(MD_OP_MULH, 2'b01, 32'hffffffff, 32'hffffffff, 32'hffffffff);
		add_entry(MD_OP_MULH, 2'b01, 32'h80000000, 32'h80000000, 32'hc0000000);
		add_entry(MD_OP_MULH, 2'b00, 32'h00010001, 32'h00010001, 32'h00000001);
		add_entry(MD_OP_MULH, 2'b11, 32'h80000000, 32'h7fffffff, 32'hc0000000);
		add_entry(MD_OP_DIV, 2'b00, 32'd100, 32'd7, 32'd14);
		add_entry(MD_OP_REM, 2'b00, 32'd100, 32'd7, 32'd2);
		add_entry(MD_OP_DIV, 2'b11, 32'hfffffff9, 32'h00000002, 32'hfffffffd);
		add_entry(MD_OP_REM, 2'b11, 32'hfffffff9, 32'h00000002, 32'hffffffff);
		add_entry(MD_OP_DIV, 2'b11, 32'h00000007, 32'hfffffffe, 32'hfffffffd);
		add_entry(MD_OP_REM, 2'b11, 32'h00000007, 32'hfffffffe, 32'h00000001);
		add_entry(MD_OP_DIV, 2'b11, 32'hffffff9c, 32'hfffffff9, 32'h0000000e);
		add_entry(MD_OP_REM, 2'b11, 32'hffffff9c, 32'hfffffff9, 32'hfffffffe);
		add_entry(MD_OP_DIV, 2'b11, 32'h80000000, 32'hffffffff, 32'h80000000); // Overflow case.
		add_entry(MD_OP_REM, 2'b11, 32'h80000000, 32'hffffffff, 32'h00000000);
		add_entry(MD_OP_DIV, 2'b00, 32'h80000000, 32'hffffffff, 32'h00000000);
		add_entry(MD_OP_REM, 2'b00, 32'h80000000, 32'hffffffff, 32'h80000000);
		add_entry(MD_OP_DIV, 2'b00, 32'hffffffff, 32'h00000001, 32'hffffffff);
		add_entry(MD_OP_DIV, 2'b00, 32'h12345678, 32'h00000000, 32'hffffffff);
		add_entry(MD_OP_REM, 2'b00, 32'h12345678, 32'h00000000, 32'h12345678);
		add_entry(MD_OP_DIV, 2'b11, 32'hfffffff9, 32'h00000000, 32'hffffffff);
		add_entry(MD_OP_REM, 2'b11, 32'hfffffff9, 32'h00000000, 32'hfffffff9);
		for (int i = 0; i < num_random; i++) begin
			r = lcg_next();
			op = md_op_e'(r[1:0]);
			mode = r[3:2];
			if (op == MD_OP_DIV || op == MD_OP_REM) begin
				mode = {r[2], r[2]};
			end else if (mode == 2'b10) begin
				mode = 2'b11; // Only the three RISC-V sign modes.
			end
			a = lcg_next();
			b = lcg_next() >> r[8:4]; // Spread the divisor size.
			add_entry(op, mode, a, b, model_result(op, mode, a, b));
		end
	endtask

	// One full four-phase handshake with back-pressure before the release.
	task automatic apply_entry(input entry_t e, input int idx);
		int cycles;
		string tag;
		tag = $sformatf("entry %0d", idx);
		@(posedge clk);
		op_a <= e.a;
		op_b <= e.b;
		operator <= e.op;
		signed_mode <= e.mode;
		req <= 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
			if (cycles > ack_limit) report_timeout({tag, " ack_o never rose"});
		end while (!ack);
		case (e.op)
			MD_OP_MULL: check_latency(cycles, 5, 5, tag);
			MD_OP_MULH: check_latency(cycles, 6, 6, tag);
			default: begin
				if (e.b == '0) begin
					check_latency(cycles, div_zero_cycles, div_zero_cycles, tag);
				end else begin
					check_latency(cycles, div_cycles, div_cycles, tag);
				end
			end
		endcase
		check_result(result, e.expected, e.op, tag);
		repeat (10) begin
			@(posedge clk);
			@(negedge clk);
			check_ack(ack, 1'b1, {tag, " ack_o under back-pressure"});
			check_result(result, e.expected, e.op, {tag, " under back-pressure"});
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		check_ack(ack, 1'b1, {tag, " ack_o before req_i low is seen"});
		cycles = 0;
		while (ack) begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
			if (cycles > 4) report_timeout({tag, " ack_o never fell"});
		end
		@(negedge clk);
		check_ack(ack, 1'b0, {tag, " ack_o while idle"});
	endtask

	initial begin
		rst_n = 1'b0;
		req = 1'b0;
		op_a = '0;
		op_b = '0;
		operator = MD_OP_MULL;
		signed_mode = '0;
		build_table();
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_ack(ack, 1'b0, "ack_o after reset");
		foreach (table_q[i]) begin
			apply_entry(table_q[i], i);
		end
		$display("Test completed successfully");
		$finish;
	end

	initial begin
		repeat (reset_cycles) @(posedge clk);
		repeat (table_q.size() * cycles_per_entry) @(posedge clk);
		$display("The run timed out before all %0d entries were done", table_q.size());
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== sim.f ====
hw/md_pkg.sv
hw/md_operand_stage.sv
hw/md_multiplier.sv
hw/md_divider.sv
hw/md_result_port.sv
hw/md_unit.sv
tb/md_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= md_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
